// ==== hw/dlx_flit_pkg.sv ====
////////////////////
// Flit and lane geometry of the 512-bit
// receive datapath
////////////////////
package dlx_flit_pkg;

  // A full flit fills the whole word
  localparam int FLIT_W     = 512;

  // One lane carries exactly one short flit
  localparam int LANE_W     = 128;

  localparam int NUM_LANES  = FLIT_W / LANE_W;    // Four lanes per word
  localparam int LANE_IDX_W = $clog2(NUM_LANES);  // Start lane index width

endpackage

// ==== hw/dlx_short_flit_pkg.sv ====
////////////////////
// Short flit header layout, lane union
// and CRC-16 constants
////////////////////
package dlx_short_flit_pkg;

  localparam int SFN_BIT = 82;  // Short flit next, same spot in every lane
  localparam int ACK_W   = 5;
  localparam int RECAL_W = 2;
  localparam int CRC_W   = 16;

  // CCITT polynomial, no final xor
  localparam logic [CRC_W-1:0] CRC_POLY = 16'h1021;

  // Header view of one lane, msb first
  typedef struct packed {
    logic [35:0]        rsvd_hi;   // Bits 127..92
    logic [ACK_W-1:0]   ack_cnt;   // Bits 91..87
    logic [RECAL_W-1:0] recal;     // Bits 86..85
    logic [1:0]         rsvd_mid;  // Bits 84..83
    logic               sfn;       // Bit 82
    logic [65:0]        rsvd_lo;   // Bits 81..16
    logic [CRC_W-1:0]   crc;       // Check bits 15..0
  } short_hdr_t;

  // Same 128 bits, read raw by the CRC and by field for status
  typedef union packed {
    logic [dlx_flit_pkg::LANE_W-1:0] raw;
    short_hdr_t                      hdr;
  } short_lane_u;

endpackage

// ==== hw/crc16_lane_check.sv ====
////////////////////
// CRC-16 residue check over one lane
////////////////////
module crc16_lane_check (
  input  dlx_short_flit_pkg::short_lane_u lane,  // One short flit
  output logic                            bad    // Residue not zero
);

  logic [dlx_short_flit_pkg::CRC_W-1:0] residue;

  // Serial CRC unrolled over all 128 bits
  // Msb first, register starts at zero
  always_comb begin
    logic fb;
    residue = '0;
    for (int i = dlx_flit_pkg::LANE_W - 1; i >= 0; i--) begin
      fb      = residue[dlx_short_flit_pkg::CRC_W-1] ^ lane.raw[i];  // Feedback bit
      residue = {residue[dlx_short_flit_pkg::CRC_W-2:0], 1'b0}
              ^ ({dlx_short_flit_pkg::CRC_W{fb}} & dlx_short_flit_pkg::CRC_POLY);
    end
  end

  // Check bits appended in 15..0 cancel to zero on a clean lane
  assign bad = |residue;

endmodule

// ==== hw/short_flit_parser.sv ====
////////////////////
// Input capture register and lane walk FSM
// Classifies each lane as short flit, full
// flit start or tail of a pending flit
////////////////////
module short_flit_parser (
  input  logic                                rx_clk_in,
  input  logic                                reset,
  input  logic                                valid_in,
  input  logic [dlx_flit_pkg::FLIT_W-1:0]     flit_in,
  output logic [dlx_flit_pkg::FLIT_W-1:0]     word_q,       // Registered word
  output logic                                word_valid,   // word_q is new this cycle
  output logic [dlx_flit_pkg::NUM_LANES-1:0]  short_lanes,  // Lanes holding short flits
  output logic                                emit,         // Full flit completes here
  output logic [dlx_flit_pkg::LANE_IDX_W-1:0] emit_shift,   // Start lane of that flit
  output logic                                hold_load,    // Capture upper lanes
  output logic [dlx_flit_pkg::LANE_IDX_W-1:0] hold_lane     // Where the new flit starts
);

  logic [dlx_flit_pkg::LANE_IDX_W-1:0] start_q;     // Lane s of the pending flit
  logic [dlx_flit_pkg::LANE_IDX_W-1:0] start_nxt;
  logic                                short_next_q;
  logic                                short_next_nxt;
  logic [dlx_flit_pkg::NUM_LANES-1:0]  sfn;         // Short next bit per lane

  // Payload only moves on a valid word
  always_ff @(posedge rx_clk_in) begin
    if (valid_in) begin
      word_q <= flit_in;
    end
  end

  always_ff @(posedge rx_clk_in) begin
    if (reset) begin
      word_valid   <= 1'b0;
      start_q      <= '0;
      short_next_q <= 1'b0;
    end else begin
      word_valid   <= valid_in;
      start_q      <= start_nxt;       // Holds when no word, see decode defaults
      short_next_q <= short_next_nxt;
    end
  end

  // SFN sits at the same offset in every lane
  always_comb begin
    for (int k = 0; k < dlx_flit_pkg::NUM_LANES; k++) begin
      sfn[k] = word_q[k*dlx_flit_pkg::LANE_W + dlx_short_flit_pkg::SFN_BIT];
    end
  end

  // Lane walk
  // Lanes below s close the pending flit, then short flits chain
  // through SFN until a full flit starts or the word runs out
  always_comb begin
    logic sn;
    logic walk_done;
    start_nxt      = start_q;
    short_next_nxt = short_next_q;
    short_lanes    = '0;
    emit           = 1'b0;
    emit_shift     = start_q;
    hold_load      = 1'b0;
    hold_lane      = start_q;
    sn             = short_next_q;
    walk_done      = 1'b0;
    if (word_valid) begin
      if (start_q != '0) begin
        emit = 1'b1;                   // Tail lanes 0..s-1 finish the flit
        sn   = sfn[start_q - 1'b1];    // Last lane of that flit says what follows
      end
      start_nxt = '0;                  // Walk ending in short flits realigns to 0
      for (int k = 0; k < dlx_flit_pkg::NUM_LANES; k++) begin
        if (k >= int'(start_q) && !walk_done) begin
          if (sn) begin
            short_lanes[k] = 1'b1;
            sn             = sfn[k];
          end else begin
            walk_done = 1'b1;
            if (k == 0) begin
              emit = 1'b1;             // Aligned flit, whole word
              sn   = sfn[dlx_flit_pkg::NUM_LANES-1];
            end else begin
              start_nxt = dlx_flit_pkg::LANE_IDX_W'(k);  // Flit spills into next word
              hold_load = 1'b1;
              hold_lane = dlx_flit_pkg::LANE_IDX_W'(k);
            end
          end
        end
      end
      short_next_nxt = sn;
    end
  end

  // Strobes only follow a sampled input word
  a_strobe_after_word: assert property (@(posedge rx_clk_in) disable iff (reset)
    (emit || hold_load) |-> $past(valid_in));

  a_no_short_when_idle: assert property (@(posedge rx_clk_in) disable iff (reset)
    !$past(valid_in) |-> (short_lanes == '0));

endmodule

// ==== hw/flit_realign.sv ====
////////////////////
// Holding register for spilled lanes and
// output realignment mux
////////////////////
module flit_realign (
  input  logic                                rx_clk_in,
  input  logic                                reset,
  input  logic [dlx_flit_pkg::FLIT_W-1:0]     word_q,
  input  logic                                emit,
  input  logic [dlx_flit_pkg::LANE_IDX_W-1:0] emit_shift,
  input  logic                                hold_load,
  input  logic [dlx_flit_pkg::LANE_IDX_W-1:0] hold_lane,
  input  logic                                force_beat,  // Extra beat on CRC error
  output logic [dlx_flit_pkg::FLIT_W-1:0]     flit_out,
  output logic                                valid_out
);

  // Upper lanes of a started flit, shifted down to lane 0
  logic [3*dlx_flit_pkg::LANE_W-1:0] hold_q;
  logic [dlx_flit_pkg::FLIT_W-1:0]   flit_nxt;

  always_ff @(posedge rx_clk_in) begin
    if (hold_load) begin
      hold_q <= word_q[dlx_flit_pkg::FLIT_W-1:dlx_flit_pkg::LANE_W]
                >> ((hold_lane - 1'b1) * dlx_flit_pkg::LANE_W);
    end
  end

  // Held lanes s..3 go low, new word lanes 0..s-1 go on top
  always_comb begin
    case (emit_shift)
      2'd1: flit_nxt = {word_q[dlx_flit_pkg::LANE_W-1:0], hold_q};
      2'd2: flit_nxt = {word_q[2*dlx_flit_pkg::LANE_W-1:0],
                        hold_q[2*dlx_flit_pkg::LANE_W-1:0]};
      2'd3: flit_nxt = {word_q[3*dlx_flit_pkg::LANE_W-1:0],
                        hold_q[dlx_flit_pkg::LANE_W-1:0]};
      default: flit_nxt = word_q;  // Aligned flit
    endcase
  end

  always_ff @(posedge rx_clk_in) begin
    if (emit) begin
      flit_out <= flit_nxt;        // Forced beat leaves data as is
    end
  end

  always_ff @(posedge rx_clk_in) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= emit | force_beat;
    end
  end

  // A flit starting at lane 0 never spills
  a_hold_not_lane0: assert property (@(posedge rx_clk_in) disable iff (reset)
    hold_load |-> (hold_lane != '0));

endmodule

// ==== hw/short_flit_status.sv ====
////////////////////
// Short flit CRC checks, sticky error with
// forced valid beat, ack sum, recal status
////////////////////
module short_flit_status (
  input  logic                                   rx_clk_in,
  input  logic                                   reset,
  input  logic [dlx_flit_pkg::FLIT_W-1:0]        word_q,
  input  logic [dlx_flit_pkg::NUM_LANES-1:0]     short_lanes,
  input  logic                                   valid_out,  // From the realigner
  input  logic                                   emit,
  output logic                                   force_beat,
  output logic                                   forced_valid_out,
  output logic                                   sf_crc_error,
  output logic [dlx_short_flit_pkg::ACK_W-1:0]   sf_ack_cnt,
  output logic [dlx_short_flit_pkg::RECAL_W-1:0] sf_recal_status
);

  dlx_short_flit_pkg::short_lane_u          lanes [dlx_flit_pkg::NUM_LANES];
  logic [dlx_flit_pkg::NUM_LANES-1:0]       crc_bad;
  logic [dlx_flit_pkg::NUM_LANES-1:0]       good;      // Short and clean
  logic [dlx_flit_pkg::NUM_LANES-1:0]       lane_err;  // Short and corrupt
  logic                                     err_dly_q;
  logic [dlx_short_flit_pkg::ACK_W-1:0]     ack_sum;
  logic [dlx_short_flit_pkg::RECAL_W-1:0]   recal_pick;

  for (genvar k = 0; k < dlx_flit_pkg::NUM_LANES; k++) begin : g_lane
    assign lanes[k] = word_q[k*dlx_flit_pkg::LANE_W +: dlx_flit_pkg::LANE_W];

    crc16_lane_check u_crc (
      .lane (lanes[k]),
      .bad  (crc_bad[k])
    );
  end

  // CRC only counts on lanes that really hold short flits
  assign good     = short_lanes & ~crc_bad;
  assign lane_err = short_lanes & crc_bad;

  // Ascending walk, so the highest good lane wins the recal pick
  always_comb begin
    ack_sum    = '0;
    recal_pick = '0;
    for (int k = 0; k < dlx_flit_pkg::NUM_LANES; k++) begin
      if (good[k]) begin
        ack_sum    = ack_sum + lanes[k].hdr.ack_cnt;  // Wraps mod 32
        recal_pick = lanes[k].hdr.recal;
      end
    end
  end

  assign force_beat = sf_crc_error & ~err_dly_q;  // First cycle of the error

  always_ff @(posedge rx_clk_in) begin
    if (reset) begin
      sf_crc_error     <= 1'b0;
      err_dly_q        <= 1'b0;
      forced_valid_out <= 1'b0;
      sf_ack_cnt       <= '0;
      sf_recal_status  <= '0;
    end else begin
      // Set by any bad lane, dropped after the beat that follows the rise
      sf_crc_error     <= (|lane_err) | (sf_crc_error & ~(err_dly_q & valid_out));
      err_dly_q        <= sf_crc_error;
      forced_valid_out <= force_beat & ~emit;     // Real flit takes the beat itself
      sf_ack_cnt       <= ack_sum;
      sf_recal_status  <= recal_pick;
    end
  end

  // The realigner must turn every forced beat into a valid cycle
  a_forced_is_valid: assert property (@(posedge rx_clk_in) disable iff (reset)
    forced_valid_out |-> valid_out);

endmodule

// ==== hw/dlx_rx_short_flit_align.sv ====
////////////////////
// Receive flit realigner top level
////////////////////
module dlx_rx_short_flit_align (
  input  logic                                   rx_clk_in,
  input  logic                                   reset,
  input  logic                                   valid_in,
  input  logic [dlx_flit_pkg::FLIT_W-1:0]        flit_in,
  output logic                                   valid_out,
  output logic                                   forced_valid_out,
  output logic [dlx_flit_pkg::FLIT_W-1:0]        flit_out,
  output logic                                   sf_crc_error,
  output logic [dlx_short_flit_pkg::ACK_W-1:0]   sf_ack_cnt,
  output logic [dlx_short_flit_pkg::RECAL_W-1:0] sf_recal_status
);

  logic [dlx_flit_pkg::FLIT_W-1:0]     word_q;
  logic [dlx_flit_pkg::NUM_LANES-1:0]  short_lanes;
  logic                                emit;
  logic [dlx_flit_pkg::LANE_IDX_W-1:0] emit_shift;
  logic                                hold_load;
  logic [dlx_flit_pkg::LANE_IDX_W-1:0] hold_lane;
  logic                                force_beat;

  short_flit_parser u_parser (
    .rx_clk_in   (rx_clk_in),
    .reset       (reset),
    .valid_in    (valid_in),
    .flit_in     (flit_in),
    .word_q      (word_q),
    .word_valid  (),
    .short_lanes (short_lanes),
    .emit        (emit),
    .emit_shift  (emit_shift),
    .hold_load   (hold_load),
    .hold_lane   (hold_lane)
  );

  flit_realign u_realign (
    .rx_clk_in  (rx_clk_in),
    .reset      (reset),
    .word_q     (word_q),
    .emit       (emit),
    .emit_shift (emit_shift),
    .hold_load  (hold_load),
    .hold_lane  (hold_lane),
    .force_beat (force_beat),
    .flit_out   (flit_out),
    .valid_out  (valid_out)
  );

  short_flit_status u_status (
    .rx_clk_in        (rx_clk_in),
    .reset            (reset),
    .word_q           (word_q),
    .short_lanes      (short_lanes),
    .valid_out        (valid_out),
    .emit             (emit),
    .force_beat       (force_beat),
    .forced_valid_out (forced_valid_out),
    .sf_crc_error     (sf_crc_error),
    .sf_ack_cnt       (sf_ack_cnt),
    .sf_recal_status  (sf_recal_status)
  );

endmodule

// ==== verification/tb_dlx_rx_align.sv ====
////////////////////
// Testbench for the receive flit realigner
// Reference model, lane stream builder
// and directed tests
////////////////////
module tb_dlx_rx_align;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LW  = dlx_flit_pkg::LANE_W;
  localparam int SFN = dlx_short_flit_pkg::SFN_BIT;

  logic                                   rx_clk_in;
  logic                                   reset;
  logic                                   valid_in;
  logic [dlx_flit_pkg::FLIT_W-1:0]        flit_in;
  logic                                   valid_out;
  logic                                   forced_valid_out;
  logic [dlx_flit_pkg::FLIT_W-1:0]        flit_out;
  logic                                   sf_crc_error;
  logic [dlx_short_flit_pkg::ACK_W-1:0]   sf_ack_cnt;
  logic [dlx_short_flit_pkg::RECAL_W-1:0] sf_recal_status;

  int           m_start;           // Model start lane
  logic         m_sn;              // Model short next bit
  logic [511:0] m_hold;            // Word that started the pending flit
  logic [511:0] m_flit;            // Last flit on the output
  logic         m_known;           // flit_out defined
  logic         m_err0;            // Error two windows back
  logic         m_err1;            // Error one window back
  logic         m_valid1;
  logic [10:0]  exp_ctl_q[$];      // known, valid, forced, err, ack, recal
  logic [511:0] exp_flit_q[$];
  int           flit_kinds[$];     // 0 full, 1 short, 2 short with bad CRC
  int           forced_seen;

  dlx_rx_short_flit_align uut (
    .rx_clk_in        (rx_clk_in),
    .reset            (reset),
    .valid_in         (valid_in),
    .flit_in          (flit_in),
    .valid_out        (valid_out),
    .forced_valid_out (forced_valid_out),
    .flit_out         (flit_out),
    .sf_crc_error     (sf_crc_error),
    .sf_ack_cnt       (sf_ack_cnt),
    .sf_recal_status  (sf_recal_status)
  );

  initial begin
    rx_clk_in = 1'b0;
    forever #4 rx_clk_in = ~rx_clk_in;  // 8 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Run stopped");
  endtask

  task automatic check(input string name, input logic [511:0] got, input logic [511:0] exp);
    assert (got === exp) else abort_run($sformatf("[FAIL] %s got %0h exp %0h", name, got, exp));
  endtask

  // Bits 127..16 msb first from a zero register
  function automatic logic [15:0] crc_of(input logic [111:0] d);
    logic [15:0] c;
    c = '0;
    for (int i = 111; i >= 0; i--) begin
      c = {c[14:0], 1'b0} ^ ((c[15] ^ d[i]) ? dlx_short_flit_pkg::CRC_POLY : 16'h0);
    end
    return c;
  endfunction

  function automatic logic [127:0] rand_lane();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  function automatic logic [127:0] make_short(input logic sfn, input logic bad);
    logic [127:0] l;
    l = rand_lane();                          // Ack and recal fields random too
    l[SFN] = sfn;
    l[15:0] = crc_of(l[127:16]) ^ {15'd0, bad};  // One flipped check bit
    return l;
  endfunction

  // Expected outputs two edges after the drive edge of word w
  task automatic model_word(input logic v, input logic [511:0] w);
    logic         emit;
    logic         bad;
    logic         sn;
    logic         done;
    logic         force_b;
    logic         valid_n;
    logic         err_n;
    logic [4:0]   ack;
    logic [1:0]   recal;
    logic [127:0] l;
    int           s;
    emit  = 1'b0;
    bad   = 1'b0;
    done  = 1'b0;
    ack   = '0;
    recal = '0;
    s     = m_start;
    sn    = m_sn;
    if (v) begin
      if (s != 0) begin
        emit = 1'b1;                         // Tail lanes 0..s-1 close the pending flit
        for (int j = 0; j < 4; j++) begin
          if (j < 4 - s) m_flit[j*LW +: LW] = m_hold[(s + j)*LW +: LW];
          else m_flit[j*LW +: LW] = w[(j + s - 4)*LW +: LW];
        end
        sn = w[(s - 1)*LW + SFN];
      end
      m_start = 0;
      for (int k = s; k < 4; k++) begin
        l = w[k*LW +: LW];
        if (!done && sn) begin
          if (crc_of(l[127:16]) == l[15:0]) begin
            ack   = ack + l[91:87];          // Mod 32
            recal = l[86:85];                // Highest good lane wins
          end else begin
            bad = 1'b1;
          end
          sn = l[SFN];
        end else if (!done) begin
          done = 1'b1;
          if (k == 0) begin
            emit   = 1'b1;
            m_flit = w;
            sn     = w[3*LW + SFN];
          end else begin
            m_start = k;                     // Flit spills into the next word
            m_hold  = w;
          end
        end
      end
      m_sn    = sn;
      m_known = m_known | emit;
    end
    force_b  = m_err1 & ~m_err0;             // Error rose last window
    valid_n  = emit | force_b;
    err_n    = bad | (m_err1 & ~(m_err0 & m_valid1));
    exp_ctl_q.push_back({m_known, valid_n, force_b & ~emit, err_n, ack, recal});
    exp_flit_q.push_back(m_flit);
    m_err0   = m_err1;
    m_err1   = err_n;
    m_valid1 = valid_n;
  endtask

  // One clock: drive on the rising edge, compare on the falling edge
  task automatic cycle(input logic v, input logic [511:0] w);
    logic [10:0]  c;
    logic [511:0] f;
    @(posedge rx_clk_in);
    valid_in <= v;
    flit_in  <= w;
    model_word(v, w);
    @(negedge rx_clk_in);
    c = exp_ctl_q.pop_front();
    f = exp_flit_q.pop_front();
    check("valid_out", 512'(valid_out), 512'(c[9]));
    check("forced_valid_out", 512'(forced_valid_out), 512'(c[8]));
    check("sf_crc_error", 512'(sf_crc_error), 512'(c[7]));
    check("sf_ack_cnt", 512'(sf_ack_cnt), 512'(c[6:2]));
    check("sf_recal_status", 512'(sf_recal_status), 512'(c[1:0]));
    if (c[10]) check("flit_out", flit_out, f);
    if (forced_valid_out) forced_seen++;
  endtask

  // Pads with short flits to a word boundary, then sends with optional gaps
  task automatic send_flits(input int gap_pct);
    logic [127:0] lanes[$];
    logic [127:0] l;
    logic [511:0] w;
    logic         nxt;
    int           total;
    total = 0;
    foreach (flit_kinds[i]) total += (flit_kinds[i] == 0) ? 4 : 1;
    while (total % 4 != 0) begin
      flit_kinds.push_back(1);
      total++;
    end
    foreach (flit_kinds[i]) begin
      nxt = (i + 1 < flit_kinds.size()) && (flit_kinds[i + 1] != 0);
      if (flit_kinds[i] == 0) begin
        repeat (3) lanes.push_back(rand_lane());
        l = rand_lane();
        l[SFN] = nxt;                        // Last lane says what follows
        lanes.push_back(l);
      end else begin
        lanes.push_back(make_short(nxt, flit_kinds[i] == 2));
      end
    end
    while (lanes.size() != 0) begin
      if ($urandom_range(99) < gap_pct) repeat ($urandom_range(1, 3)) cycle(1'b0, '0);
      for (int j = 0; j < 4; j++) w[j*LW +: LW] = lanes.pop_front();
      cycle(1'b1, w);
    end
    flit_kinds.delete();
  endtask

  task automatic test_crc_error();
    int tries;
    forced_seen = 0;
    flit_kinds = {0, 2, 1, 1, 1};            // Bad flit in lane 0 of a short word
    send_flits(0);
    tries = 0;
    while (forced_seen == 0 && tries < 8) begin
      cycle(1'b0, '0);
      tries++;
    end
    assert (forced_seen != 0) else abort_run("Timeout waiting for the forced valid beat");
    tries = 0;
    while (sf_crc_error && tries < 8) begin
      cycle(1'b0, '0);
      tries++;
    end
    assert (!sf_crc_error) else abort_run("Timeout waiting for the CRC error to clear");
    flit_kinds = {0, 1, 0, 0};               // Shifted flits still realign
    send_flits(0);
  endtask

  // Control outputs stay idle after reset
  task automatic idle_after_reset();
    repeat (3) cycle(1'b0, '0);
  endtask

  // Back to back aligned flits pass straight through
  task automatic aligned_flits();
    flit_kinds = {0, 0, 0, 0};
    send_flits(0);
  endtask

  // One to three short flits push the following full flits off lane 0
  task automatic shifted_flits();
    flit_kinds = {0, 1, 0, 0, 0};
    send_flits(0);
    flit_kinds = {0, 1, 1, 0, 0};
    send_flits(0);
    flit_kinds = {0, 1, 1, 1, 0, 0, 0};
    send_flits(0);
  endtask

  task automatic ack_recal_words();
    flit_kinds = {0, 1, 1, 1, 1, 1, 1, 1, 1, 0};  // Two all-short words
    send_flits(0);
  endtask

  task automatic random_mix();
    flit_kinds.push_back(0);                 // Lane walk starts on a full flit
    repeat (59) flit_kinds.push_back(($urandom_range(99) < 40) ? 1 : 0);
    send_flits(30);
  endtask

  initial begin
    void'($urandom(22076));
    reset    = 1'b1;
    valid_in = 1'b0;
    flit_in  = '0;
    m_start  = 0;
    m_sn     = 1'b0;
    m_hold   = '0;
    m_flit   = '0;
    m_known  = 1'b0;
    m_err0   = 1'b0;
    m_err1   = 1'b0;
    m_valid1 = 1'b0;
    exp_ctl_q.push_back(11'd0);              // Two windows before the first word lands
    exp_ctl_q.push_back(11'd0);
    exp_flit_q.push_back('0);
    exp_flit_q.push_back('0);
    repeat (3) @(posedge rx_clk_in);
    reset <= 1'b0;
    idle_after_reset();
    aligned_flits();
    shifted_flits();
    ack_recal_words();
    test_crc_error();
    random_mix();
    repeat (3) cycle(1'b0, '0);
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== all.f ====
hw/dlx_flit_pkg.sv
hw/dlx_short_flit_pkg.sv
hw/crc16_lane_check.sv
hw/short_flit_parser.sv
hw/flit_realign.sv
hw/short_flit_status.sv
hw/dlx_rx_short_flit_align.sv
verification/tb_dlx_rx_align.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the flit realigner testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_dlx_rx_align -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit 1
fi

exit 0
